/* verilog/tenyr_pkg.sv */
package tenyr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    localparam reg_idx_t REG_ZERO = 4'd0;  // Hardwired zero
    localparam reg_idx_t REG_PC   = 4'd15; // Program counter

    typedef enum logic [3:0] {
        OP_OR,
        OP_AND,
        OP_ADD,
        OP_MUL,
        OP_RSVD4,
        OP_SHL,
        OP_LT,
        OP_EQ,
        OP_GT,
        OP_ANDN,
        OP_XOR,
        OP_SUB,
        OP_XNOR,
        OP_SHR,
        OP_NE,
        OP_RSVD15
    } alu_op_e;

    // Where the result goes
    typedef enum logic [1:0] {
        DR_REG       = 2'b00, // Z <- rhs
        DR_LOAD      = 2'b01, // Z <- [rhs]
        DR_STORE_RHS = 2'b10, // [Z] <- rhs
        DR_STORE_Z   = 2'b11  // [rhs] <- Z
    } deref_e;

    // Instruction word layout
    localparam int TYPE_BIT  = 30;
    localparam int DEREF_LSB = 28;
    localparam int Z_LSB     = 24;
    localparam int X_LSB     = 20;
    localparam int Y_LSB     = 16;
    localparam int OP_LSB    = 12;
    localparam int IMM_W     = 12;

endpackage

/* verilog/stage_ifs.sv */
`timescale 1ns/10ps

// Decode to execute
interface dec_exe_if;
    logic                              valid;
    tenyr_pkg::word_t                  pc_next;  // Insn address plus one
    tenyr_pkg::reg_idx_t               z_idx;
    tenyr_pkg::word_t                  z_val;
    tenyr_pkg::word_t                  x_val;
    tenyr_pkg::word_t                  y_val;
    logic [tenyr_pkg::IMM_W-1:0]       imm;
    tenyr_pkg::alu_op_e                op;
    tenyr_pkg::deref_e                 deref;
    logic                              imm_is_o; // Type bit
    logic                              illegal;

    modport src (output valid, pc_next, z_idx, z_val, x_val, y_val, imm, op, deref,
                  imm_is_o, illegal);
    modport dst (input valid, pc_next, z_idx, z_val, x_val, y_val, imm, op, deref,
                 imm_is_o, illegal);
endinterface

// Execute to writeback
interface exe_wb_if;
    logic                valid;
    tenyr_pkg::reg_idx_t z_idx;
    tenyr_pkg::word_t    z_val;
    tenyr_pkg::word_t    rhs;
    tenyr_pkg::deref_e   deref;
    logic                illegal;

    modport src (output valid, z_idx, z_val, rhs, deref, illegal);
    modport dst (input valid, z_idx, z_val, rhs, deref, illegal);
endinterface

/* verilog/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage #(
    parameter tenyr_pkg::word_t RESET_VECTOR = 32'h0000_1000
) (
    input  logic             i_clk,
    input  logic             i_reset_n,
    input  logic             i_en,
    input  logic             i_stall,
    input  logic             i_halt,
    input  logic             i_jump_valid,
    input  tenyr_pkg::word_t i_jump_target,
    output tenyr_pkg::word_t o_insn_addr,
    input  tenyr_pkg::word_t i_insn_data,
    output tenyr_pkg::word_t o_insn,
    output tenyr_pkg::word_t o_insn_pc,
    output logic             o_insn_valid
);

    tenyr_pkg::word_t pc;

    wire run     = i_en && !i_halt;
    wire advance = run && !i_jump_valid && !i_stall;

    assign o_insn_addr = pc;

    always_ff @(posedge i_clk) begin
        if (i_reset_n) begin
            pc           <= RESET_VECTOR;
            o_insn_valid <= 1'b0;
        end else if (run) begin
            if (i_jump_valid) begin // Jump wins over a stall
                pc           <= i_jump_target;
                o_insn_valid <= 1'b0;
            end else if (!i_stall) begin
                pc           <= pc + 32'd1;
                o_insn_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (advance) begin
            o_insn    <= i_insn_data;
            o_insn_pc <= pc;
        end
    end

    // Writeback must not redirect once the core is frozen by halt
    a_no_jump_in_halt: assert property (@(posedge i_clk) disable iff (i_reset_n)
        i_halt |-> !i_jump_valid);

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_en,
    input  logic                i_halt,
    input  tenyr_pkg::word_t    i_insn,
    input  tenyr_pkg::word_t    i_insn_pc,
    input  logic                i_insn_valid,
    input  logic                i_flush,
    output tenyr_pkg::reg_idx_t o_rd_x,
    output tenyr_pkg::reg_idx_t o_rd_y,
    output tenyr_pkg::reg_idx_t o_rd_z,
    input  tenyr_pkg::word_t    i_rd_x_val,
    input  tenyr_pkg::word_t    i_rd_y_val,
    input  tenyr_pkg::word_t    i_rd_z_val,
    output logic                o_stall,
    dec_exe_if.src              de,
    input  tenyr_pkg::reg_idx_t i_exe_wr_idx,
    input  logic                i_exe_wr_en
);

    tenyr_pkg::deref_e  deref;
    tenyr_pkg::alu_op_e op;
    tenyr_pkg::word_t   pc_next;
    tenyr_pkg::word_t   x_val, y_val, z_val;
    logic               is_insn, top_ones, slot_valid, need_z, hazard;

    assign is_insn    = !i_insn[31];
    assign top_ones   = &i_insn[31:28];       // Illegal marker
    assign slot_valid = i_insn_valid && (is_insn || top_ones); // Others are no-ops

    assign deref  = tenyr_pkg::deref_e'(i_insn[tenyr_pkg::DEREF_LSB +: 2]);
    assign op     = tenyr_pkg::alu_op_e'(i_insn[tenyr_pkg::OP_LSB +: 4]);
    assign o_rd_z = i_insn[tenyr_pkg::Z_LSB +: 4];
    assign o_rd_x = i_insn[tenyr_pkg::X_LSB +: 4];
    assign o_rd_y = i_insn[tenyr_pkg::Y_LSB +: 4];

    // Register 15 reads as the address after this one
    assign pc_next = i_insn_pc + 32'd1;
    assign x_val   = (o_rd_x == tenyr_pkg::REG_PC) ? pc_next : i_rd_x_val;
    assign y_val   = (o_rd_y == tenyr_pkg::REG_PC) ? pc_next : i_rd_y_val;
    assign z_val   = (o_rd_z == tenyr_pkg::REG_PC) ? pc_next : i_rd_z_val;

    // Stores read Z as well
    assign need_z = deref[1];
    assign hazard = i_insn_valid && is_insn && i_exe_wr_en &&
                    (i_exe_wr_idx == o_rd_x || i_exe_wr_idx == o_rd_y ||
                     (need_z && i_exe_wr_idx == o_rd_z));
    assign o_stall = hazard && i_en && !i_halt;

    always_ff @(posedge i_clk) begin
        if (i_reset_n)
            de.valid <= 1'b0;
        else if (i_en && !i_halt)
            de.valid <= slot_valid && !o_stall && !i_flush; // Bubble on stall
    end

    always_ff @(posedge i_clk) begin
        if (i_en && !i_halt) begin
            de.pc_next  <= pc_next;
            de.z_idx    <= o_rd_z;
            de.z_val    <= z_val;
            de.x_val    <= x_val;
            de.y_val    <= y_val;
            de.imm      <= i_insn[tenyr_pkg::IMM_W-1:0];
            de.op       <= op;
            de.deref    <= deref;
            de.imm_is_o <= i_insn[tenyr_pkg::TYPE_BIT];
            de.illegal  <= top_ones;
        end
    end

    // The bubble clears the execute destination, so the stall cannot repeat
    a_stall_single: assert property (@(posedge i_clk) disable iff (i_reset_n)
        o_stall |=> !o_stall);

endmodule

/* verilog/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  tenyr_pkg::reg_idx_t i_rd_x,
    input  tenyr_pkg::reg_idx_t i_rd_y,
    input  tenyr_pkg::reg_idx_t i_rd_z,
    output tenyr_pkg::word_t    o_rd_x_val,
    output tenyr_pkg::word_t    o_rd_y_val,
    output tenyr_pkg::word_t    o_rd_z_val,
    input  logic                i_wr_en,
    input  tenyr_pkg::reg_idx_t i_wr_idx,
    input  tenyr_pkg::word_t    i_wr_data
);

    tenyr_pkg::word_t regs [1:15]; // No storage behind register 0

    // Zero register first, then the write in flight
    function automatic tenyr_pkg::word_t read_port(tenyr_pkg::reg_idx_t idx);
        if (idx == tenyr_pkg::REG_ZERO)
            return '0;
        else if (i_wr_en && idx == i_wr_idx)
            return i_wr_data;
        else
            return regs[idx];
    endfunction

    always_comb begin
        o_rd_x_val = read_port(i_rd_x);
        o_rd_y_val = read_port(i_rd_y);
        o_rd_z_val = read_port(i_rd_z);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset_n) begin
            for (int i = 1; i < 16; i++)
                regs[i] <= '0;
        end else if (i_wr_en && i_wr_idx != tenyr_pkg::REG_ZERO) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    a_no_zero_write: assert property (@(posedge i_clk) disable iff (i_reset_n)
        i_wr_en |-> i_wr_idx != tenyr_pkg::REG_ZERO);

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_en,
    input  logic                i_halt,
    input  logic                i_flush,
    dec_exe_if.dst              de,
    exe_wb_if.src               ew,
    output tenyr_pkg::reg_idx_t o_wr_idx,
    output logic                o_wr_en
);

    localparam int EXT_W = 32 - tenyr_pkg::IMM_W;

    tenyr_pkg::word_t imm_ext, opnd, addend, alu;
    logic             rsvd_op;

    assign imm_ext = {{EXT_W{de.imm[tenyr_pkg::IMM_W-1]}}, de.imm};
    assign opnd    = de.imm_is_o ? imm_ext : de.y_val;
    assign addend  = de.imm_is_o ? de.y_val : imm_ext;
    assign rsvd_op = de.op inside {tenyr_pkg::OP_RSVD4, tenyr_pkg::OP_RSVD15};

    always_comb begin
        case (de.op)
            tenyr_pkg::OP_OR:   alu = de.x_val | opnd;
            tenyr_pkg::OP_AND:  alu = de.x_val & opnd;
            tenyr_pkg::OP_ADD:  alu = de.x_val + opnd;
            tenyr_pkg::OP_MUL:  alu = de.x_val * opnd;
            tenyr_pkg::OP_SHL:  alu = de.x_val << opnd;
            tenyr_pkg::OP_LT:   alu = {32{$signed(de.x_val) < $signed(opnd)}};
            tenyr_pkg::OP_EQ:   alu = {32{de.x_val == opnd}};
            tenyr_pkg::OP_GT:   alu = {32{$signed(de.x_val) > $signed(opnd)}};
            tenyr_pkg::OP_ANDN: alu = de.x_val & ~opnd;
            tenyr_pkg::OP_XOR:  alu = de.x_val ^ opnd;
            tenyr_pkg::OP_SUB:  alu = de.x_val - opnd;
            tenyr_pkg::OP_XNOR: alu = de.x_val ^ ~opnd;
            tenyr_pkg::OP_SHR:  alu = de.x_val >> opnd; // Logical
            tenyr_pkg::OP_NE:   alu = {32{de.x_val != opnd}};
            default:            alu = '0;               // Reserved, flagged below
        endcase
    end

    // Destination for the hazard check in decode
    assign o_wr_idx = de.z_idx;
    assign o_wr_en  = de.valid && !de.deref[1] &&
                      de.z_idx != tenyr_pkg::REG_ZERO && de.z_idx != tenyr_pkg::REG_PC;

    always_ff @(posedge i_clk) begin
        if (i_reset_n)
            ew.valid <= 1'b0;
        else if (i_en && !i_halt)
            ew.valid <= de.valid && !i_flush;
    end

    always_ff @(posedge i_clk) begin
        if (i_en && !i_halt) begin
            ew.z_idx   <= de.z_idx;
            ew.z_val   <= de.z_val;
            ew.rhs     <= alu + addend;
            ew.deref   <= de.deref;
            ew.illegal <= de.illegal || rsvd_op;
        end
    end

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/10ps

module writeback_stage (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_en,
    exe_wb_if.dst               ew,
    output tenyr_pkg::word_t    o_mem_addr,
    output tenyr_pkg::word_t    o_mem_wdata,
    input  tenyr_pkg::word_t    i_mem_rdata,
    output logic                o_mem_we,
    output logic                o_mem_re,
    output logic                o_wr_en,
    output tenyr_pkg::reg_idx_t o_wr_idx,
    output tenyr_pkg::word_t    o_wr_data,
    output logic                o_jump_valid,
    output tenyr_pkg::word_t    o_jump_target,
    output logic                o_halt
);

    logic live, to_reg;

    // Illegal or frozen slots have no effect
    assign live   = ew.valid && !ew.illegal && i_en && !o_halt;
    assign to_reg = live && (ew.deref == tenyr_pkg::DR_REG || ew.deref == tenyr_pkg::DR_LOAD);

    assign o_mem_re    = live && ew.deref == tenyr_pkg::DR_LOAD;
    assign o_mem_we    = live && ew.deref[1];
    assign o_mem_addr  = (ew.deref == tenyr_pkg::DR_STORE_RHS) ? ew.z_val : ew.rhs;
    assign o_mem_wdata = (ew.deref == tenyr_pkg::DR_STORE_Z) ? ew.z_val : ew.rhs;

    assign o_wr_idx  = ew.z_idx;
    assign o_wr_data = (ew.deref == tenyr_pkg::DR_LOAD) ? i_mem_rdata : ew.rhs;
    assign o_wr_en   = to_reg && ew.z_idx != tenyr_pkg::REG_ZERO;

    // Writing register 15 redirects fetch
    assign o_jump_valid  = to_reg && ew.z_idx == tenyr_pkg::REG_PC;
    assign o_jump_target = o_wr_data;

    always_ff @(posedge i_clk) begin
        if (i_reset_n)
            o_halt <= 1'b0;
        else if (i_en && ew.valid && ew.illegal)
            o_halt <= 1'b1; // Sticky until reset
    end

    a_mem_excl: assert property (@(posedge i_clk) disable iff (i_reset_n)
        !(o_mem_we && o_mem_re));

endmodule

/* verilog/tenyr_core.sv */
`timescale 1ns/10ps

module tenyr_core #(
    parameter tenyr_pkg::word_t RESET_VECTOR = 32'h0000_1000
) (
    input  logic             i_clk,
    input  logic             i_reset_n,
    input  logic             i_en,
    output tenyr_pkg::word_t o_insn_addr,
    input  tenyr_pkg::word_t i_insn_data,
    output tenyr_pkg::word_t o_mem_addr,
    output tenyr_pkg::word_t o_mem_wdata,
    input  tenyr_pkg::word_t i_mem_rdata,
    output logic             o_mem_we,
    output logic             o_mem_re,
    output logic             o_halt
);

    tenyr_pkg::word_t    insn, insn_pc, jump_target, wr_data;
    tenyr_pkg::word_t    rd_x_val, rd_y_val, rd_z_val;
    tenyr_pkg::reg_idx_t rd_x, rd_y, rd_z, wr_idx, exe_wr_idx;
    logic                insn_valid, stall, jump_valid, wr_en, exe_wr_en;

    dec_exe_if de_if ();
    exe_wb_if  ew_if ();

    fetch_stage #(.RESET_VECTOR(RESET_VECTOR)) fetch_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(i_en),
        .i_stall(stall), .i_halt(o_halt),
        .i_jump_valid(jump_valid), .i_jump_target(jump_target),
        .o_insn_addr(o_insn_addr), .i_insn_data(i_insn_data),
        .o_insn(insn), .o_insn_pc(insn_pc), .o_insn_valid(insn_valid)
    );

    decode_stage decode_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(i_en), .i_halt(o_halt),
        .i_insn(insn), .i_insn_pc(insn_pc), .i_insn_valid(insn_valid),
        .i_flush(jump_valid),
        .o_rd_x(rd_x), .o_rd_y(rd_y), .o_rd_z(rd_z),
        .i_rd_x_val(rd_x_val), .i_rd_y_val(rd_y_val), .i_rd_z_val(rd_z_val),
        .o_stall(stall), .de(de_if.src),
        .i_exe_wr_idx(exe_wr_idx), .i_exe_wr_en(exe_wr_en)
    );

    register_file regs_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_rd_x(rd_x), .i_rd_y(rd_y), .i_rd_z(rd_z),
        .o_rd_x_val(rd_x_val), .o_rd_y_val(rd_y_val), .o_rd_z_val(rd_z_val),
        .i_wr_en(wr_en), .i_wr_idx(wr_idx), .i_wr_data(wr_data)
    );

    execute_stage execute_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(i_en), .i_halt(o_halt),
        .i_flush(jump_valid), .de(de_if.dst), .ew(ew_if.src),
        .o_wr_idx(exe_wr_idx), .o_wr_en(exe_wr_en)
    );

    writeback_stage writeback_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(i_en), .ew(ew_if.dst),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
        .o_mem_we(o_mem_we), .o_mem_re(o_mem_re),
        .o_wr_en(wr_en), .o_wr_idx(wr_idx), .o_wr_data(wr_data),
        .o_jump_valid(jump_valid), .o_jump_target(jump_target), .o_halt(o_halt)
    );

endmodule

/* verification/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

    // Type, deref mode, Z, X, Y, opcode, immediate
    function automatic tenyr_pkg::word_t encode_insn(int t, int d, int z, int x, int y,
                                                     int op, int imm);
        return {1'b0, t[0], d[1:0], z[3:0], x[3:0], y[3:0], op[3:0], imm[11:0]};
    endfunction

    // Loaded at RESET_VECTOR, one word per address
    localparam int PROG_LEN = 50;
    localparam tenyr_pkg::word_t PROGRAM [PROG_LEN] = '{
        encode_insn(0, 0, 1, 0, 0, 'h0, 'h06C),     // r1 = 0x6C
        encode_insn(0, 0, 2, 0, 0, 'h0, 'h006),     // r2 = 6
        encode_insn(0, 0, 4, 0, 0, 'h0, 'h040),     // r4 = store base
        // Every legal opcode into [r4], type 0 with I = -1, type 1 with I = 5
        encode_insn(0, 2, 4, 1, 2, 'h0, -1), encode_insn(1, 2, 4, 1, 2, 'h0, 5),
        encode_insn(0, 2, 4, 1, 2, 'h1, -1), encode_insn(1, 2, 4, 1, 2, 'h1, 5),
        encode_insn(0, 2, 4, 1, 2, 'h2, -1), encode_insn(1, 2, 4, 1, 2, 'h2, 5),
        encode_insn(0, 2, 4, 1, 2, 'h3, -1), encode_insn(1, 2, 4, 1, 2, 'h3, 5),
        encode_insn(0, 2, 4, 1, 2, 'h5, -1), encode_insn(1, 2, 4, 1, 2, 'h5, 5),
        encode_insn(0, 2, 4, 1, 2, 'h6, -1), encode_insn(1, 2, 4, 1, 2, 'h6, 5),
        encode_insn(0, 2, 4, 1, 2, 'h7, -1), encode_insn(1, 2, 4, 1, 2, 'h7, 5),
        encode_insn(0, 2, 4, 1, 2, 'h8, -1), encode_insn(1, 2, 4, 1, 2, 'h8, 5),
        encode_insn(0, 2, 4, 1, 2, 'h9, -1), encode_insn(1, 2, 4, 1, 2, 'h9, 5),
        encode_insn(0, 2, 4, 1, 2, 'hA, -1), encode_insn(1, 2, 4, 1, 2, 'hA, 5),
        encode_insn(0, 2, 4, 1, 2, 'hB, -1), encode_insn(1, 2, 4, 1, 2, 'hB, 5),
        encode_insn(0, 2, 4, 1, 2, 'hC, -1), encode_insn(1, 2, 4, 1, 2, 'hC, 5),
        encode_insn(0, 2, 4, 1, 2, 'hD, -1), encode_insn(1, 2, 4, 1, 2, 'hD, 5),
        encode_insn(0, 2, 4, 1, 2, 'hE, -1), encode_insn(1, 2, 4, 1, 2, 'hE, 5),
        encode_insn(0, 0, 5, 1, 2, 'h2, 0),         // r5 = r1 + r2
        encode_insn(0, 0, 6, 5, 2, 'hB, 0),         // r6 = r5 - r2, stalls
        encode_insn(0, 0, 7, 2, 2, 'h2, 0),         // r7 = r2 + r2
        encode_insn(0, 2, 4, 6, 5, 'h2, 0),         // [r4] = r6 + r5, r6 written through
        encode_insn(0, 2, 4, 7, 0, 'h0, 0),         // [r4] = r7
        encode_insn(0, 1, 8, 4, 0, 'h0, 0),         // r8 = [r4]
        encode_insn(0, 3, 8, 4, 0, 'h0, 1),         // [r4 + 1] = r8
        encode_insn(0, 0, 0, 1, 0, 'h0, 0),         // r0 = r1, no effect
        encode_insn(0, 3, 0, 4, 0, 'h0, 3),         // [r4 + 3] = r0
        encode_insn(0, 3, 15, 4, 0, 'h0, 2),        // [r4 + 2] = own address + 1
        encode_insn(0, 0, 15, 15, 0, 'h0, 3),       // Jump over three words
        encode_insn(0, 3, 1, 4, 0, 'h0, 4),         // Skipped
        encode_insn(0, 3, 1, 4, 0, 'h0, 4),         // Skipped
        encode_insn(0, 3, 1, 4, 0, 'h0, 4),         // Skipped
        encode_insn(0, 3, 15, 4, 0, 'h0, 5),        // Jump target
        32'h8765_4321,                              // Discarded no-op
        encode_insn(0, 3, 2, 4, 0, 'h0, 6),         // [r4 + 6] = r2
        32'hF000_0000,                              // Illegal, halts
        encode_insn(0, 3, 1, 4, 0, 'h0, 7)          // Never stored
    };

    // Address and data of each store, in program order
    localparam int EXP_LEN = 35;
    localparam logic [63:0] EXPECTED [EXP_LEN] = '{
        // Type 0 and type 1 results, two opcodes per line in encoding order
        {32'h40, 32'h6D}, {32'h40, 32'h73}, {32'h40, 32'h03}, {32'h40, 32'h0A},
        {32'h40, 32'h71}, {32'h40, 32'h77}, {32'h40, 32'h287}, {32'h40, 32'h222},
        {32'h40, 32'h1AFF}, {32'h40, 32'hD86}, {32'h40, 32'hFFFFFFFF}, {32'h40, 32'h6},
        {32'h40, 32'hFFFFFFFF}, {32'h40, 32'h6}, {32'h40, 32'hFFFFFFFE}, {32'h40, 32'h5},
        {32'h40, 32'h67}, {32'h40, 32'h6E}, {32'h40, 32'h69}, {32'h40, 32'h6F},
        {32'h40, 32'h65}, {32'h40, 32'h6D}, {32'h40, 32'hFFFFFF94}, {32'h40, 32'hFFFFFF9C},
        {32'h40, 32'h0}, {32'h40, 32'h9}, {32'h40, 32'hFFFFFFFE}, {32'h40, 32'h5},
        {32'h40, 32'hDE}, {32'h40, 32'h0C}, {32'h41, 32'h0C}, {32'h43, 32'h0},
        {32'h42, 32'h1029}, {32'h45, 32'h102E}, {32'h46, 32'h6}
    };

    // The one load in the program reads the store base
    localparam tenyr_pkg::word_t LOAD_ADDR  = 32'h40;
    localparam int               LOAD_COUNT = 1;

`endif

/* verification/tb_tenyr_core.sv */
`timescale 1ns/10ps

module tb_tenyr_core;

    localparam tenyr_pkg::word_t RESET_VECTOR = 32'h0000_1000;
    localparam int RESET_CYCLES = 5;

    `include "tb_program.svh"

    localparam int TIMEOUT_CYCLES = 10 * PROG_LEN + 100;

    logic             i_clk = 1'b0;
    logic             i_reset_n;
    logic             i_en;
    tenyr_pkg::word_t o_insn_addr, i_insn_data;
    tenyr_pkg::word_t o_mem_addr, o_mem_wdata, i_mem_rdata;
    logic             o_mem_we, o_mem_re, o_halt;

    tenyr_pkg::word_t dmem [0:255];
    tenyr_pkg::word_t insn_offset;
    int               cycles = 0;
    int               store_idx = 0;
    int               load_count = 0;
    int               addr_errors = 0;
    int               data_errors = 0;
    int               other_errors = 0;

    tenyr_core #(.RESET_VECTOR(RESET_VECTOR)) tenyr_core_i (.*);

    always #10 i_clk = ~i_clk;

    always @(posedge i_clk) cycles <= cycles + 1;

    // Both memories answer in the same cycle
    assign insn_offset = o_insn_addr - RESET_VECTOR;
    assign i_insn_data = (insn_offset < PROG_LEN) ? PROGRAM[insn_offset] : 32'h8000_0000;
    assign i_mem_rdata = dmem[o_mem_addr[7:0]];

    initial begin
        for (int a = 0; a < 256; a++)
            dmem[a] = '0;
    end

    // Walk the expected table, one entry per store
    always @(posedge i_clk) begin
        if (!i_reset_n && o_mem_we) begin
            dmem[o_mem_addr[7:0]] <= o_mem_wdata;
            if (store_idx < EXP_LEN) begin
                assert (o_mem_addr == EXPECTED[store_idx][63:32]) else begin
                    $display("ERROR: o_mem_addr 0x%08h, expected 0x%08h at store %0d",
                             o_mem_addr, EXPECTED[store_idx][63:32], store_idx);
                    addr_errors++;
                end
                assert (o_mem_wdata == EXPECTED[store_idx][31:0]) else begin
                    $display("ERROR: o_mem_wdata 0x%08h, expected 0x%08h at store %0d",
                             o_mem_wdata, EXPECTED[store_idx][31:0], store_idx);
                    data_errors++;
                end
            end else begin
                $display("A store to 0x%08h came after the last expected store", o_mem_addr);
                other_errors++;
            end
            store_idx++;
        end
    end

    // Read strobe, one cycle per load
    always @(posedge i_clk) begin
        if (!i_reset_n && o_mem_re) begin
            assert (o_mem_addr == LOAD_ADDR) else begin
                $display("ERROR: o_mem_addr 0x%08h, expected 0x%08h at load %0d",
                         o_mem_addr, LOAD_ADDR, load_count);
                addr_errors++;
            end
            load_count++;
        end
    end

    // Random stretches with the core disabled
    initial begin
        int unsigned gap;
        void'($urandom(23));
        i_en = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #2 i_en = 1'b1;
        forever begin
            @(posedge i_clk);
            if ($urandom % 6 == 0) begin
                gap = 1 + $urandom % 4;
                #2 i_en = 1'b0;
                repeat (gap) @(posedge i_clk);
                #2 i_en = 1'b1;
            end
        end
    end

    initial begin
        i_reset_n = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #2 i_reset_n = 1'b0;
        while (!o_halt && cycles < TIMEOUT_CYCLES)
            @(negedge i_clk);
        if (!o_halt) begin
            $display("Timeout: the core never halted within %0d cycles", TIMEOUT_CYCLES);
            other_errors++;
        end
        repeat (5) @(negedge i_clk); // Frozen core, no further stores
        assert (store_idx >= EXP_LEN) else begin
            $display("Only %0d of %0d expected stores were seen", store_idx, EXP_LEN);
            other_errors++;
        end
        assert (load_count == LOAD_COUNT) else begin
            $display("Saw %0d load strobe cycles where %0d were expected",
                     load_count, LOAD_COUNT);
            other_errors++;
        end
        $display("Errors: %0d address, %0d data, %0d other",
                 addr_errors, data_errors, other_errors);
        if (addr_errors + data_errors + other_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+verification
verilog/tenyr_pkg.sv
verilog/stage_ifs.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/tenyr_core.sv
verification/tb_tenyr_core.sv

/* Bender.yml */
package:
  name: tenyr_core

sources:
  - verilog/tenyr_pkg.sv
  - verilog/stage_ifs.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/register_file.sv
  - verilog/execute_stage.sv
  - verilog/writeback_stage.sv
  - verilog/tenyr_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_tenyr_core.sv
